/* src/sq_params.svh */
// ========================================
// Store queue sizing. SQ_IDX_W must equal
// log2(SQ_DEPTH) and SQ_DEPTH must be a
// power of two for the ring to wrap cleanly
// ========================================
`ifndef SQ_PARAMS_SVH
`define SQ_PARAMS_SVH

// Number of entries in the ring
`define SQ_DEPTH  8

// Store address and data widths
`define SQ_ADDR_W 32
`define SQ_DATA_W 32

// ROB index width, sized to the ROB
`define SQ_TAG_W  5

// Ring pointer width
`define SQ_IDX_W  3

`endif

/* src/sq_types_pkg.sv */
// ========================================
// Data path types of the store queue.
// The payload struct is 71 bits with the
// default widths and is packed MSB first
// ========================================
`include "sq_params.svh"

package sq_types_pkg;

    // Store width only since the LSU formats the byte lanes
    typedef enum logic [1:0] {
        SQ_SB = 2'b00,
        SQ_SH = 2'b01,
        SQ_SW = 2'b10
    } sq_op_e;

    // ROB tag used to match retirement
    typedef logic [`SQ_TAG_W-1:0] sq_tag_t;

    typedef logic [`SQ_ADDR_W-1:0] sq_addr_t;
    typedef logic [`SQ_DATA_W-1:0] sq_data_t;

    // Payload written at allocation and presented at launch
    typedef struct packed {
        sq_op_e   op;
        sq_tag_t  tag;
        sq_addr_t addr;
        sq_data_t data;
    } sq_store_t;

endpackage

/* src/sq_ctrl_pkg.sv */
// ========================================
// Control types of the store queue for
// the entry lifecycle, the LSU outcome
// bits and the ring pointer
// ========================================
`include "sq_params.svh"

package sq_ctrl_pkg;

    // INVALID holds nothing, VALID is speculative,
    // NONSPECULATIVE is retired by the ROB and waits for launch,
    // LAUNCHED sits in the LSU until the outcome arrives
    typedef enum logic [2:0] {
        SQ_INVALID        = 3'b000,
        SQ_VALID          = 3'b001,
        SQ_MHQ_FILL_WAIT  = 3'b010,
        SQ_NONSPECULATIVE = 3'b011,
        SQ_LAUNCHED       = 3'b100
    } sq_state_e;

    // Outcome of a launched store as reported by the LSU and MHQ
    typedef struct packed {
        logic retry;
        logic replay;
        logic mhq_retry;
        logic mhq_replay;
    } sq_update_t;

    // Index into the ring of entries
    typedef logic [`SQ_IDX_W-1:0] sq_idx_t;

endpackage

/* src/sq_entry.sv */
// ========================================
// One store queue entry. The caller must
// route launch and update strobes only to
// the entry at the head of the ring
// ========================================
`timescale 1ns/1ps

module sq_entry
    import sq_types_pkg::*;
    import sq_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_flush,
    input  logic       i_alloc_en,
    input  sq_store_t  i_alloc_store,
    input  logic       i_launch_en,
    input  logic       i_update_en,
    input  sq_update_t i_update,
    input  logic       i_mhq_fill_en,
    input  logic       i_rob_retire_en,
    input  sq_tag_t    i_rob_retire_tag,
    output sq_store_t  o_store,
    output sq_state_e  o_state,
    output logic       o_empty,
    output logic       o_committed,
    output logic       o_freed,
    output logic       o_rob_retire_ack
);

    sq_store_t store_r;
    sq_state_e state_r;
    sq_state_e state_next;
    logic      rob_match;

    // The ROB retires in order, so at most one VALID entry carries the tag
    assign rob_match = i_rob_retire_en && (state_r == SQ_VALID) &&
                       (store_r.tag == i_rob_retire_tag);

    always_comb begin
        sq_state_e outcome_state;

        // Replay of either kind relaunches as soon as the LSU allows
        // A miss retry parks until the fill, unless the fill lands this cycle
        // Anything else means the store wrote the cache and is done
        if (i_update.replay || i_update.mhq_replay) begin
            outcome_state = SQ_NONSPECULATIVE;
        end else if (i_update.retry && i_update.mhq_retry) begin
            outcome_state = i_mhq_fill_en ? SQ_NONSPECULATIVE : SQ_MHQ_FILL_WAIT;
        end else begin
            outcome_state = SQ_INVALID;
        end

        state_next = state_r;
        case (state_r)
            SQ_INVALID: begin
                if (i_alloc_en) state_next = SQ_VALID;
            end
            SQ_VALID: begin
                // Flush wins over a retire in the same cycle
                if (i_flush) begin
                    state_next = SQ_INVALID;
                end else if (rob_match) begin
                    state_next = SQ_NONSPECULATIVE;
                end
            end
            SQ_MHQ_FILL_WAIT: begin
                if (i_mhq_fill_en) state_next = SQ_NONSPECULATIVE;
            end
            SQ_NONSPECULATIVE: begin
                if (i_launch_en) state_next = SQ_LAUNCHED;
            end
            SQ_LAUNCHED: begin
                if (i_update_en) state_next = outcome_state;
            end
            default: state_next = SQ_INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= SQ_INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Payload is only meaningful while the state is not INVALID
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            store_r <= i_alloc_store;
        end
    end

    assign o_store          = store_r;
    assign o_state          = state_r;
    assign o_empty          = (state_r == SQ_INVALID);
    // Committed entries survive a flush
    assign o_committed      = (state_r != SQ_INVALID) && (state_r != SQ_VALID);
    // High in the cycle before the edge that frees the entry
    assign o_freed          = (state_r == SQ_LAUNCHED) && (state_next == SQ_INVALID);
    assign o_rob_retire_ack = rob_match;

    // The ring only writes a new store into an entry that holds none
    a_alloc_invalid: assert property (@(posedge clk) disable iff (i_rst)
        i_alloc_en |-> (state_r == SQ_INVALID));

    // The LSU only reports on a store that it actually holds
    a_update_launched: assert property (@(posedge clk) disable iff (i_rst)
        i_update_en |-> (state_r == SQ_LAUNCHED));

endmodule

/* src/sq_ring_ctrl.sv */
// ========================================
// Ring pointers for the store queue. The
// committed entries are assumed to sit
// contiguously from the head
// ========================================
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_ring_ctrl
    import sq_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_flush,
    input  logic                 i_alloc_valid,
    input  logic [`SQ_DEPTH-1:0] i_freed,
    input  logic [`SQ_DEPTH-1:0] i_committed,
    output logic                 o_alloc_ready,
    output logic [`SQ_DEPTH-1:0] o_alloc_en,
    output sq_idx_t              o_head
);

    localparam int DEPTH = `SQ_DEPTH;
    localparam int IDX_W = `SQ_IDX_W;
    localparam logic [IDX_W:0] FULL_CNT = `SQ_DEPTH;

    sq_idx_t          head_r;
    sq_idx_t          tail_r;
    logic [IDX_W:0]   count_r;
    logic [IDX_W:0]   commit_cnt;
    logic [DEPTH-1:0] head_onehot;
    logic             alloc_fire;
    logic             freed_any;

    // No allocation is taken while a flush rebuilds the tail
    assign o_alloc_ready = (count_r != FULL_CNT) && !i_flush;
    assign alloc_fire    = i_alloc_valid && o_alloc_ready;
    assign freed_any     = |i_freed;

    always_comb begin
        commit_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            head_onehot[i] = (head_r == sq_idx_t'(i));
            o_alloc_en[i]  = alloc_fire && (tail_r == sq_idx_t'(i));
            commit_cnt     = commit_cnt + {{IDX_W{1'b0}}, i_committed[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head_r  <= '0;
            tail_r  <= '0;
            count_r <= '0;
        end else begin
            if (freed_any) head_r <= head_r + 1'b1;
            if (i_flush) begin
                // A store freed in the flush cycle was counted as committed
                tail_r  <= head_r + sq_idx_t'(commit_cnt);
                count_r <= commit_cnt - {{IDX_W{1'b0}}, freed_any};
            end else begin
                if (alloc_fire) tail_r <= tail_r + 1'b1;
                if (alloc_fire && !freed_any) begin
                    count_r <= count_r + 1'b1;
                end else if (!alloc_fire && freed_any) begin
                    count_r <= count_r - 1'b1;
                end
            end
        end
    end

    assign o_head = head_r;

    a_count_bound: assert property (@(posedge clk) disable iff (i_rst)
        count_r <= FULL_CNT);

    // Entries free in order, so only the head may report completion
    a_freed_head: assert property (@(posedge clk) disable iff (i_rst)
        freed_any |-> (i_freed == head_onehot));

endmodule

/* src/store_queue.sv */
// ========================================
// Store queue top. One store is in the LSU
// at a time and later stores wait behind
// the head until it completes
// ========================================
`timescale 1ns/1ps
`include "sq_params.svh"

module store_queue
    import sq_types_pkg::*;
    import sq_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,

    // Allocation from the issue stage in program order
    input  logic       i_alloc_valid,
    input  sq_store_t  i_alloc_store,
    output logic       o_alloc_ready,

    // ROB retirement
    input  logic       i_rob_retire_en,
    input  sq_tag_t    i_rob_retire_tag,
    output logic       o_rob_retire_ack,

    // Launch into the LSU pipeline
    output logic       o_launch_valid,
    output sq_store_t  o_launch_store,
    input  logic       i_launch_ready,

    // LSU outcome for the launched store
    input  logic       i_update_en,
    input  sq_update_t i_update,

    // Broadcast strobes
    input  logic       i_mhq_fill_en,
    input  logic       i_flush
);

    localparam int DEPTH = `SQ_DEPTH;

    sq_store_t        entry_store [DEPTH];
    sq_state_e        entry_state [DEPTH];
    logic [DEPTH-1:0] entry_empty;
    logic [DEPTH-1:0] entry_committed;
    logic [DEPTH-1:0] entry_freed;
    logic [DEPTH-1:0] entry_ack;
    logic [DEPTH-1:0] alloc_en;
    sq_idx_t          head;
    logic             launch_fire;

    sq_ring_ctrl u_ring_ctrl (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_flush       (i_flush),
        .i_alloc_valid (i_alloc_valid),
        .i_freed       (entry_freed),
        .i_committed   (entry_committed),
        .o_alloc_ready (o_alloc_ready),
        .o_alloc_en    (alloc_en),
        .o_head        (head)
    );

    // Launch and update go only to the head because one store at most is in flight
    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        sq_entry u_entry (
            .clk              (clk),
            .i_rst            (i_rst),
            .i_flush          (i_flush),
            .i_alloc_en       (alloc_en[i]),
            .i_alloc_store    (i_alloc_store),
            .i_launch_en      (launch_fire && (head == sq_idx_t'(i))),
            .i_update_en      (i_update_en && (head == sq_idx_t'(i))),
            .i_update         (i_update),
            .i_mhq_fill_en    (i_mhq_fill_en),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_store          (entry_store[i]),
            .o_state          (entry_state[i]),
            .o_empty          (entry_empty[i]),
            .o_committed      (entry_committed[i]),
            .o_freed          (entry_freed[i]),
            .o_rob_retire_ack (entry_ack[i])
        );
    end

    // The head state stays NONSPECULATIVE until the handshake, so the
    // launch port holds steady under back-pressure
    assign o_launch_valid   = (entry_state[head] == SQ_NONSPECULATIVE);
    assign o_launch_store   = entry_store[head];
    assign launch_fire      = o_launch_valid && i_launch_ready;
    assign o_rob_retire_ack = |entry_ack;

    // The ring must never write over an entry that still holds a store
    a_alloc_empty: assert property (@(posedge clk) disable iff (i_rst)
        (alloc_en & ~entry_empty) == '0);

    // An offered store stays on the port until the LSU takes it
    a_launch_hold: assert property (@(posedge clk) disable iff (i_rst)
        (o_launch_valid && !i_launch_ready) |=> (o_launch_valid && $stable(o_launch_store)));

endmodule

/* verif/sq_clock_gen.sv */
// ========================================
// Free running testbench clock that starts
// low, with a 100 ns period by default
// ========================================
`timescale 1ns/1ps

module sq_clock_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

/* verif/sq_checker.sv */
// ========================================
// Model of the store queue that predicts
// the outputs and compares them on every
// rising edge. Tags of VALID stores must
// be distinct and retire in program order
// ========================================
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_checker
    import sq_types_pkg::*;
    import sq_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_alloc_valid,
    input  sq_store_t  i_alloc_store,
    input  logic       i_alloc_ready,
    input  logic       i_rob_retire_en,
    input  sq_tag_t    i_rob_retire_tag,
    input  logic       i_rob_retire_ack,
    input  logic       i_launch_valid,
    input  sq_store_t  i_launch_store,
    input  logic       i_launch_ready,
    input  logic       i_update_en,
    input  sq_update_t i_update,
    input  logic       i_mhq_fill_en,
    input  logic       i_flush,
    output int         o_errors
);

    localparam int W = $bits(sq_store_t);

    typedef struct packed {
        logic      alloc_ready;
        logic      ack;
        logic      launch_valid;
        sq_store_t store;
    } expect_t;

    // Oldest store sits at index 0, in program order
    sq_store_t model_store [$];
    sq_state_e model_state [$];
    expect_t   expected;

    // Expected outputs from the model state before the edge
    function automatic expect_t predict_ports(input logic flush, input logic retire_en,
                                              input sq_tag_t tag);
        expect_t e;
        e = '0;
        e.alloc_ready = (model_state.size() < `SQ_DEPTH) && !flush;
        for (int i = 0; i < model_state.size(); i++) begin
            if (retire_en && model_state[i] == SQ_VALID && model_store[i].tag == tag) begin
                e.ack = 1'b1;
            end
        end
        if (model_state.size() > 0) begin
            e.launch_valid = (model_state[0] == SQ_NONSPECULATIVE);
            e.store        = model_store[0];
        end
        return e;
    endfunction

    // Where a launched store goes once the LSU reports
    function automatic sq_state_e outcome_state(input sq_update_t upd, input logic fill);
        if (upd.replay || upd.mhq_replay) return SQ_NONSPECULATIVE;
        if (upd.retry && upd.mhq_retry) return fill ? SQ_NONSPECULATIVE : SQ_MHQ_FILL_WAIT;
        return SQ_INVALID;
    endfunction

    task automatic compare_value(input string name, input logic [W-1:0] exp_v,
                                 input logic [W-1:0] act_v);
        if (exp_v !== act_v) begin
            o_errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    // Move every stored entry by its own pre-edge state, then drop the freed ones
    task automatic apply_edge(input logic take_alloc);
        sq_state_e next;
        for (int i = 0; i < model_state.size(); i++) begin
            next = model_state[i];
            case (model_state[i])
                SQ_VALID: begin
                    if (i_flush) begin
                        next = SQ_INVALID;
                    end else if (i_rob_retire_en && model_store[i].tag == i_rob_retire_tag) begin
                        next = SQ_NONSPECULATIVE;
                    end
                end
                SQ_MHQ_FILL_WAIT: if (i_mhq_fill_en) next = SQ_NONSPECULATIVE;
                SQ_NONSPECULATIVE: if (i == 0 && i_launch_ready) next = SQ_LAUNCHED;
                SQ_LAUNCHED: if (i_update_en) next = outcome_state(i_update, i_mhq_fill_en);
                default: next = model_state[i];
            endcase
            model_state[i] = next;
        end
        for (int i = model_state.size() - 1; i >= 0; i--) begin
            if (model_state[i] == SQ_INVALID) begin
                model_state.delete(i);
                model_store.delete(i);
            end
        end
        if (take_alloc) begin
            model_state.push_back(SQ_VALID);
            model_store.push_back(i_alloc_store);
        end
    endtask

    initial o_errors = 0;

    // Registers update in the NBA region, so the outputs read here are pre-edge
    always @(posedge clk) begin
        if (i_rst) begin
            model_state.delete();
            model_store.delete();
        end else begin
            expected = predict_ports(i_flush, i_rob_retire_en, i_rob_retire_tag);
            compare_value("o_alloc_ready", W'(expected.alloc_ready), W'(i_alloc_ready));
            compare_value("o_rob_retire_ack", W'(expected.ack), W'(i_rob_retire_ack));
            compare_value("o_launch_valid", W'(expected.launch_valid), W'(i_launch_valid));
            if (expected.launch_valid) begin
                compare_value("o_launch_store", expected.store, i_launch_store);
            end
            apply_edge(i_alloc_valid && expected.alloc_ready);
        end
    end

endmodule

/* verif/store_queue_tb.sv */
// ========================================
// Store queue testbench. Directed cases run
// first, then 500 random cycles. Inputs
// change on the falling edge only
// ========================================
`timescale 1ns/1ps
`include "sq_params.svh"

module store_queue_tb
    import sq_types_pkg::*;
    import sq_ctrl_pkg::*;
();

    localparam int LIMIT = 50;
    // Outcome bits in the order retry, replay, mhq_retry, mhq_replay
    localparam sq_update_t UPD_DONE   = 4'b0000;
    localparam sq_update_t UPD_REPLAY = 4'b0100;
    localparam sq_update_t UPD_MISS   = 4'b1010;

    logic       clk;
    logic       rst;
    logic       alloc_valid;
    sq_store_t  alloc_store;
    logic       alloc_ready;
    logic       retire_en;
    sq_tag_t    retire_tag;
    logic       retire_ack;
    logic       launch_valid;
    sq_store_t  launch_store;
    logic       launch_ready;
    logic       update_en;
    sq_update_t update;
    logic       fill_en;
    logic       flush;
    int         check_errors;
    int         stalls;
    int         seed;
    sq_tag_t    next_tag;
    sq_tag_t    pending [$];
    logic       in_lsu;

    sq_clock_gen i_clock_gen (.o_clk(clk));

    store_queue i_store_queue (
        .clk(clk), .i_rst(rst),
        .i_alloc_valid(alloc_valid), .i_alloc_store(alloc_store), .o_alloc_ready(alloc_ready),
        .i_rob_retire_en(retire_en), .i_rob_retire_tag(retire_tag),
        .o_rob_retire_ack(retire_ack),
        .o_launch_valid(launch_valid), .o_launch_store(launch_store),
        .i_launch_ready(launch_ready),
        .i_update_en(update_en), .i_update(update),
        .i_mhq_fill_en(fill_en), .i_flush(flush)
    );

    sq_checker i_checker (
        .clk(clk), .i_rst(rst),
        .i_alloc_valid(alloc_valid), .i_alloc_store(alloc_store), .i_alloc_ready(alloc_ready),
        .i_rob_retire_en(retire_en), .i_rob_retire_tag(retire_tag),
        .i_rob_retire_ack(retire_ack),
        .i_launch_valid(launch_valid), .i_launch_store(launch_store),
        .i_launch_ready(launch_ready),
        .i_update_en(update_en), .i_update(update),
        .i_mhq_fill_en(fill_en), .i_flush(flush), .o_errors(check_errors)
    );

    // Unretired tags in program order, and whether a store sits in the LSU
    always @(posedge clk) begin
        if (rst) begin
            pending.delete();
            in_lsu = 1'b0;
        end else begin
            if (flush) begin
                pending.delete();
            end else if (retire_ack && pending.size() > 0) begin
                pending.pop_front();
            end
            if (alloc_valid && alloc_ready) pending.push_back(alloc_store.tag);
            if (launch_valid && launch_ready) begin
                in_lsu = 1'b1;
            end else if (update_en) begin
                in_lsu = 1'b0;
            end
        end
    end

    task automatic drive_idle();
        alloc_valid  = 1'b0;
        retire_en    = 1'b0;
        launch_ready = 1'b0;
        update_en    = 1'b0;
        update       = '0;
        fill_en      = 1'b0;
        flush        = 1'b0;
    endtask

    // Tags count up so that VALID stores never share one
    function automatic sq_store_t random_store();
        sq_store_t s;
        s.op     = sq_op_e'(($random(seed) & 32'h7fff_ffff) % 3);
        s.tag    = next_tag;
        s.addr   = $random(seed);
        s.data   = $random(seed);
        next_tag = next_tag + 1'b1;
        return s;
    endfunction

    task automatic alloc_one();
        int waited;
        waited      = 0;
        alloc_valid = 1'b1;
        alloc_store = random_store();
        @(posedge clk);
        while (!alloc_ready && waited < LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!alloc_ready) begin
            stalls++;
            $display("Stall: the queue refused a new store for %0d cycles", LIMIT);
        end
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    task automatic retire_tag_once(input sq_tag_t tag);
        retire_en  = 1'b1;
        retire_tag = tag;
        @(negedge clk);
        retire_en  = 1'b0;
    endtask

    // Hold back-pressure for a while, then take the head and report an outcome
    task automatic launch_head(input int hold, input sq_update_t outcome);
        int waited;
        waited = 0;
        while (!launch_valid && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!launch_valid) begin
            stalls++;
            $display("Stall: no store was offered to the LSU for %0d cycles", LIMIT);
        end else begin
            repeat (hold) @(negedge clk);
            launch_ready = 1'b1;
            @(negedge clk);
            launch_ready = 1'b0;
            update_en    = 1'b1;
            update       = outcome;
            @(negedge clk);
            update_en    = 1'b0;
            update       = '0;
        end
    endtask

    task automatic run_random(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            drive_idle();
            alloc_valid = ($random(seed) & 1) == 1;
            if (alloc_valid) alloc_store = random_store();
            if (pending.size() > 0 && ($random(seed) & 1) == 1) begin
                retire_en  = 1'b1;
                retire_tag = pending[0];
            end
            launch_ready = ($random(seed) & 1) == 1;
            if (in_lsu && ($random(seed) & 1) == 1) begin
                update_en = 1'b1;
                update    = sq_update_t'($random(seed));
            end
            fill_en = ($random(seed) & 3) == 0;
            flush   = ($random(seed) & 31) == 0;
            @(negedge clk);
        end
        drive_idle();
    endtask

    initial begin
        sq_tag_t t;
        seed        = 36539;
        stalls      = 0;
        next_tag    = '0;
        alloc_store = '0;
        retire_tag  = '0;
        drive_idle();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fill the ring, then free one store to open a slot
        repeat (`SQ_DEPTH) alloc_one();
        repeat (2) @(negedge clk);
        retire_tag_once(pending[0]);
        launch_head(0, UPD_DONE);
        alloc_one();

        // Ack for a VALID tag and none for a repeat or an absent tag
        t = pending[0];
        retire_tag_once(t);
        retire_tag_once(t);
        retire_tag_once(next_tag + 5'd8);

        // Launch in order with back-pressure on the first store
        retire_tag_once(pending[0]);
        retire_tag_once(pending[0]);
        launch_head(3, UPD_DONE);
        launch_head(0, UPD_DONE);

        // Replay relaunches at once while a miss waits for the fill
        retire_tag_once(pending[0]);
        launch_head(0, UPD_REPLAY);
        launch_head(0, UPD_MISS);
        repeat (3) @(negedge clk);
        fill_en = 1'b1;
        @(negedge clk);
        fill_en = 1'b0;
        launch_head(0, UPD_DONE);
        launch_head(0, UPD_DONE);

        // Flush keeps the two committed stores and new ones follow them
        retire_tag_once(pending[0]);
        retire_tag_once(pending[0]);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        alloc_one();
        alloc_one();
        retire_tag_once(pending[0]);
        retire_tag_once(pending[0]);
        repeat (4) launch_head(0, UPD_DONE);

        run_random(500);
        repeat (2) @(negedge clk);
        $display("Run complete with %0d check errors and %0d stalls", check_errors, stalls);
        if (check_errors == 0 && stalls == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/sq_types_pkg.sv
src/sq_ctrl_pkg.sv
src/sq_entry.sv
src/sq_ring_ctrl.sv
src/store_queue.sv
verif/sq_clock_gen.sv
verif/sq_checker.sv
verif/store_queue_tb.sv

/* Bender.yml */
package:
  name: store_queue

sources:
  - include_dirs:
      - src
    files:
      - src/sq_types_pkg.sv
      - src/sq_ctrl_pkg.sv
      - src/sq_entry.sv
      - src/sq_ring_ctrl.sv
      - src/store_queue.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/sq_clock_gen.sv
      - verif/sq_checker.sv
      - verif/store_queue_tb.sv
